// File: Bender.yml
package:
  name: exe_stage

sources:
  - logic/lc3b_types.sv
  - logic/alu.sv
  - logic/alg_unit.sv
  - logic/ex_branch_res.sv
  - logic/exe_stage.sv
  - target: test
    files:
      - dv/exe_stage_chk.sv
      - dv/exe_stage_tb.sv

// File: dv/exe_stage_chk.sv
`timescale 1ns/1ns

module exe_stage_chk (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic br_taken,
	input logic pip_flush,
	input logic alg_done,
	input logic alg_accept
);
	int fail_count = 0;

	flush_gated: assert property (@(posedge clk) disable iff (reset)
		pip_flush |-> br_taken && !stall) else begin
		$error("pip_flush high without a taken branch or under stall");
		fail_count++;
	end

	done_single: assert property (@(posedge clk) disable iff (reset)
		alg_done |=> !alg_done) else begin
		$error("alg_done high on two consecutive cycles");
		fail_count++;
	end

	// the start sample counts as cycle 0
	done_latency: assert property (@(posedge clk) disable iff (reset)
		alg_accept |-> ##17 alg_done) else begin
		$error("alg_done did not follow the accepted start by 17 cycles");
		fail_count++;
	end

	done_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !alg_done) else begin
		$error("alg_done high during reset");
		fail_count++;
	end

endmodule : exe_stage_chk

bind exe_stage exe_stage_chk i_exe_stage_chk (
	.clk(clk),
	.reset(reset),
	.stall(stall),
	.br_taken(br_taken),
	.pip_flush(pip_flush),
	.alg_done(alg_done),
	.alg_accept(i_alg_unit.accept)
);

// File: dv/exe_stage_tb.sv
`timescale 1ns/1ns

module exe_stage_tb;
	import lc3b_types::*;

	typedef struct packed {
		logic stall;
		lc3b_ipacket ipacket;
		lc3b_ipacket mem_ipacket;
		lc3b_word sext;
		lc3b_word sr1;
		lc3b_word sr2;
		lc3b_fwd_sel opa_sel;
		lc3b_fwd_sel opb_sel;
		lc3b_fwd_sel sr_sel;
		lc3b_word mem_fwd;
		lc3b_word wb_fwd;
		// bubble_count first, then the six miss counters
		lc3b_word [6:0] cnt;
	} stim_t;

	typedef struct packed {
		lc3b_word alu_out;
		lc3b_word bradd_out;
		lc3b_word sr_store;
		lc3b_word pc_addr_out;
		lc3b_pc_sel pcmux_sel;
		logic br_taken;
		logic pip_flush;
	} expect_t;

	logic clk;
	logic reset;
	stim_t stim;
	lc3b_word hi_model;
	lc3b_word lo_model;
	logic checking;
	string test_name;
	int seed = 32'h2b40;
	lc3b_word alu_out;
	lc3b_word bradd_out;
	lc3b_word sr_store;
	lc3b_word pc_addr_out;
	lc3b_pc_sel pcmux_sel;
	logic br_taken;
	logic pip_flush;
	logic alg_done;

	exe_stage #(
		.alg_steps(16)
	) i_exe_stage (
		.clk(clk),
		.reset(reset),
		.stall(stim.stall),
		.ipacket(stim.ipacket),
		.mem_ipacket(stim.mem_ipacket),
		.sext(stim.sext),
		.sr1(stim.sr1),
		.sr2(stim.sr2),
		.opa_sel(stim.opa_sel),
		.opb_sel(stim.opb_sel),
		.sr_sel(stim.sr_sel),
		.mem_data_forward(stim.mem_fwd),
		.wb_data_forward(stim.wb_fwd),
		.bubble_count(stim.cnt[0]),
		.l1i_read_miss(stim.cnt[1]),
		.l1i_write_miss(stim.cnt[2]),
		.l1d_read_miss(stim.cnt[3]),
		.l1d_write_miss(stim.cnt[4]),
		.l2_read_miss(stim.cnt[5]),
		.l2_write_miss(stim.cnt[6]),
		.alu_out(alu_out),
		.bradd_out(bradd_out),
		.sr_store(sr_store),
		.pc_addr_out(pc_addr_out),
		.pcmux_sel(pcmux_sel),
		.br_taken(br_taken),
		.pip_flush(pip_flush),
		.alg_done(alg_done)
	);

	function automatic lc3b_word forward_pick(input lc3b_fwd_sel sel, input lc3b_word rf,
			input lc3b_word mem, input lc3b_word wb);
		case (sel)
			2'd0: return rf;
			2'd1: return mem;
			2'd2: return wb;
			default: return '0;
		endcase
	endfunction

	function automatic expect_t exe_model(input stim_t s, input lc3b_word hi, input lc3b_word lo);
		expect_t e;
		lc3b_word a;
		lc3b_word b;
		lc3b_word res;
		lc3b_nzp cc;
		int sh;
		a = forward_pick(s.opa_sel, s.sr1, s.mem_fwd, s.wb_fwd);
		b = forward_pick(s.opb_sel, s.ipacket.alumux_sel ? s.sext : s.sr2, s.mem_fwd, s.wb_fwd);
		sh = b[3:0];
		case (s.ipacket.aluop)
			alu_add: res = a + b;
			alu_and: res = a & b;
			alu_not: res = ~a;
			alu_pass_a: res = a;
			alu_pass_b: res = b;
			alu_sll: res = a << sh;
			alu_srl: res = a >> sh;
			default: res = lc3b_word'({{16{a[15]}}, a} >> sh);
		endcase
		case (s.ipacket.alu_res_sel)
			4'd0: e.alu_out = res;
			4'd8: e.alu_out = lo;
			4'd9: e.alu_out = hi;
			default: e.alu_out = (s.ipacket.alu_res_sel < 4'd8) ?
				s.cnt[s.ipacket.alu_res_sel - 4'd1] : '0;
		endcase
		e.sr_store = forward_pick(s.sr_sel, s.sr2, s.mem_fwd, s.wb_fwd);
		e.bradd_out = s.sext + (s.ipacket.braddmux_sel ? s.sr2 : s.ipacket.pc);
		if (s.mem_ipacket.set_cc) begin
			cc = {s.mem_fwd[15], s.mem_fwd == 16'h0, !s.mem_fwd[15] && s.mem_fwd != 16'h0};
		end else begin
			cc = s.ipacket.cc;
		end
		e.pcmux_sel = pc_seq;
		if (s.ipacket.opcode == op_br && (s.ipacket.nzp & cc) != 3'b000) begin
			e.pcmux_sel = pc_bradd;
		end else if (s.ipacket.opcode == op_jsr && !s.ipacket.braddmux_sel) begin
			e.pcmux_sel = pc_bradd;
		end else if (s.ipacket.opcode == op_jsr || s.ipacket.opcode == op_jmp) begin
			e.pcmux_sel = pc_reg;
		end
		e.br_taken = (e.pcmux_sel != pc_seq);
		e.pc_addr_out = (e.pcmux_sel == pc_reg) ? e.alu_out : e.bradd_out;
		e.pip_flush = e.br_taken && !s.stall;
		return e;
	endfunction

	// packs {hi, lo} from the multiply and divide rules
	function automatic logic [31:0] alg_expect(input lc3b_word a, input lc3b_word b,
			input logic div);
		if (!div) begin
			return 32'(a) * 32'(b);
		end
		if (b == 16'h0) begin
			return {a, 16'hffff};
		end
		return {a % b, a / b};
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string what, input lc3b_word exp, input lc3b_word act);
		if (act !== exp) begin
			fail_stop($sformatf("[ERROR] %s %s: expected %h, actual %h",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_sel(input string what, input lc3b_pc_sel exp, input lc3b_pc_sel act);
		if (act !== exp) begin
			fail_stop($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
				test_name, what, exp, act));
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			fail_stop($sformatf("[ERROR] %s %s: expected %b, actual %b",
				test_name, what, exp, act));
		end
	endtask

	task automatic randomize_stim();
		logic [319:0] r;
		for (int i = 0; i < 10; i++) begin
			r[i*32 +: 32] = $random(seed);
		end
		stim = r[$bits(stim_t)-1:0];
		stim.ipacket.alg_start = 1'b0;
		stim.ipacket.load_alg_reg = 1'b0;
	endtask

	// kind 0 alu and forwarding, 1 branches, 2 result select sweep
	task automatic run_vectors(input string name, input int count, input int kind);
		int pick;
		test_name = name;
		for (int n = 0; n < count; n++) begin
			@(negedge clk);
			randomize_stim();
			if (kind == 1) begin
				pick = $unsigned($random(seed)) % 4;
				stim.ipacket.alu_res_sel = 4'd0;
				if (pick == 2) begin
					stim.ipacket.opcode = op_jmp;
				end else if (pick == 3) begin
					stim.ipacket.opcode = op_jsr;
				end else begin
					stim.ipacket.opcode = op_br;
				end
				// register targets come through the alu as pass-a
				if (pick >= 2) begin
					stim.ipacket.aluop = alu_pass_a;
				end
			end else begin
				stim.ipacket.opcode = op_add;
				stim.ipacket.alu_res_sel = (kind == 2) ? lc3b_res_sel'(n) : 4'd0;
			end
		end
	endtask

	task automatic run_alg(input lc3b_word a, input lc3b_word b, input logic div);
		int edges;
		logic [31:0] result;
		test_name = div ? "divide" : "multiply";
		@(negedge clk);
		randomize_stim();
		stim.ipacket.opcode = op_alg;
		stim.ipacket.alu_res_sel = 4'd8;
		stim.ipacket.op_x_bits = div;
		stim.ipacket.alg_start = 1'b1;
		stim.ipacket.load_alg_reg = 1'b1;
		stim.ipacket.alumux_sel = 1'b0;
		stim.opa_sel = fwd_rf;
		stim.opb_sel = fwd_rf;
		stim.sr1 = a;
		stim.sr2 = b;
		@(negedge clk);
		stim.ipacket.alg_start = 1'b0;
		// rising edges seen since the one that sampled the start
		edges = 0;
		while (!alg_done && edges < 40) begin
			@(negedge clk);
			edges++;
		end
		if (!alg_done) begin
			fail_stop("alg_done never arrived within 40 cycles of the start");
		end
		if (edges + 1 != 17) begin
			fail_stop($sformatf("[ERROR] %s done edge: expected 17, actual %0d",
				test_name, edges + 1));
		end
		@(negedge clk);
		result = alg_expect(a, b, div);
		hi_model = result[31:16];
		lo_model = result[15:0];
		stim.ipacket.load_alg_reg = 1'b0;
		@(negedge clk);
		stim.ipacket.alu_res_sel = 4'd9;
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// compare one time unit before each rising edge
	initial begin
		expect_t e;
		forever begin
			@(negedge clk);
			#1;
			if (i_exe_stage.i_exe_stage_chk.fail_count != 0) begin
				fail_stop("concurrent assertions in exe_stage_chk failed");
			end
			if (checking) begin
				e = exe_model(stim, hi_model, lo_model);
				check_word("alu_out", e.alu_out, alu_out);
				check_word("bradd_out", e.bradd_out, bradd_out);
				check_word("sr_store", e.sr_store, sr_store);
				check_word("pc_addr_out", e.pc_addr_out, pc_addr_out);
				check_sel("pcmux_sel", e.pcmux_sel, pcmux_sel);
				check_bit("br_taken", e.br_taken, br_taken);
				check_bit("pip_flush", e.pip_flush, pip_flush);
			end
		end
	end

	initial begin
		lc3b_word a;
		lc3b_word b;
		reset = 1'b1;
		stim = '0;
		hi_model = '0;
		lo_model = '0;
		checking = 1'b0;
		test_name = "reset";
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checking = 1'b1;
		check_bit("alg_done", 1'b0, alg_done);
		stim.ipacket.alu_res_sel = 4'd8;
		@(negedge clk);
		stim.ipacket.alu_res_sel = 4'd9;

		run_vectors("alu_forward", 100, 0);
		run_vectors("branch", 150, 1);
		run_vectors("flush_stall", 60, 1);
		run_vectors("counter_select", 32, 2);
		for (int i = 0; i < 8; i++) begin
			a = $random(seed);
			b = $random(seed);
			// a small divisor gives a wide quotient
			if (i == 5) begin
				b = b >> 12;
			end
			// the last one divides by zero
			if (i == 7) begin
				b = '0;
			end
			run_alg(a, b, i[0]);
		end

		@(negedge clk);
		checking = 1'b0;
		if (i_exe_stage.i_exe_stage_chk.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_stop("concurrent assertions in exe_stage_chk failed");
		end
	end

endmodule : exe_stage_tb

// File: logic/alg_unit.sv
`timescale 1ns/1ns

module alg_unit #(
	parameter int alg_steps = 16
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic op_x_bits,
	input lc3b_types::lc3b_word opa,
	input lc3b_types::lc3b_word opb,
	output logic done,
	output lc3b_types::lc3b_word hi_bits,
	output lc3b_types::lc3b_word lo_bits
);
	import lc3b_types::*;

	localparam int count_w = $clog2(alg_steps);

	typedef enum logic [1:0] {st_idle, st_run, st_finish} alg_state_t;

	alg_state_t state;
	logic [count_w-1:0] count;
	logic is_div;
	// multiplicand or divisor
	lc3b_word operand;
	// upper product half or partial remainder
	lc3b_word acc;
	// multiplier shifting out, or dividend out and quotient in
	lc3b_word mq;
	logic [16:0] mul_sum;
	logic [16:0] div_shift;
	logic [16:0] div_diff;
	logic accept;

	assign accept = (state == st_idle) && start;

	always_comb begin
		mul_sum = {1'b0, acc};
		if (mq[0]) begin
			mul_sum = {1'b0, acc} + {1'b0, operand};
		end
		div_shift = {acc, mq[15]};
		div_diff = div_shift - {1'b0, operand};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			count <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_run;
						count <= '0;
					end
				end
				st_run: begin
					count <= count + 1'b1;
					if (count == count_w'(alg_steps - 1)) begin
						state <= st_finish;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			is_div <= op_x_bits;
			operand <= opb;
			acc <= '0;
			mq <= opa;
		end else if (state == st_run) begin
			if (is_div) begin
				// restoring step, a zero divisor always fits
				if (!div_diff[16]) begin
					acc <= div_diff[15:0];
					mq <= {mq[14:0], 1'b1};
				end else begin
					acc <= div_shift[15:0];
					mq <= {mq[14:0], 1'b0};
				end
			end else begin
				acc <= mul_sum[16:1];
				mq <= {mul_sum[0], mq[15:1]};
			end
		end
	end

	assign done = (state == st_finish);
	assign hi_bits = acc;
	assign lo_bits = mq;

endmodule : alg_unit

// File: logic/alu.sv
`timescale 1ns/1ns

module alu (
	input lc3b_types::lc3b_aluop aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);
	import lc3b_types::*;

	logic [3:0] shamt;

	assign shamt = b[3:0];

	always_comb begin
		case (aluop)
			alu_add: begin
				f = a + b;
			end
			alu_and: begin
				f = a & b;
			end
			alu_not: begin
				f = ~a;
			end
			alu_pass_a: begin
				f = a;
			end
			alu_pass_b: begin
				f = b;
			end
			alu_sll: begin
				f = a << shamt;
			end
			alu_srl: begin
				f = a >> shamt;
			end
			default: begin
				f = lc3b_word'($signed(a) >>> shamt);
			end
		endcase
	end

endmodule : alu

// File: logic/ex_branch_res.sv
`timescale 1ns/1ns

module ex_branch_res (
	input lc3b_types::lc3b_ipacket ex_ipacket,
	input lc3b_types::lc3b_ipacket mem_ipacket,
	input lc3b_types::lc3b_word ex_alu_res,
	input lc3b_types::lc3b_word ex_addr_res,
	input lc3b_types::lc3b_word mem_res,
	input logic stall,
	output logic branch_enable,
	output lc3b_types::lc3b_word br_addr,
	output lc3b_types::lc3b_pc_sel pcmux_sel,
	output logic flush
);
	import lc3b_types::*;

	lc3b_nzp cc;
	logic mem_neg;
	logic mem_zero;

	// memory stage result overrides the stale register-file codes
	assign mem_neg = mem_res[15];
	assign mem_zero = (mem_res == '0);
	assign cc = mem_ipacket.set_cc ? {mem_neg, mem_zero, ~mem_neg & ~mem_zero} : ex_ipacket.cc;

	always_comb begin
		branch_enable = 1'b0;
		pcmux_sel = pc_seq;
		case (ex_ipacket.opcode)
			op_br: begin
				branch_enable = |(ex_ipacket.nzp & cc);
				pcmux_sel = branch_enable ? pc_bradd : pc_seq;
			end
			op_jsr: begin
				branch_enable = 1'b1;
				pcmux_sel = ex_ipacket.braddmux_sel ? pc_reg : pc_bradd;
			end
			op_jmp: begin
				branch_enable = 1'b1;
				pcmux_sel = pc_reg;
			end
			default: begin
				branch_enable = 1'b0;
			end
		endcase
	end

	// register target comes through the alu as pass-a
	assign br_addr = (pcmux_sel == pc_reg) ? ex_alu_res : ex_addr_res;
	assign flush = branch_enable & ~stall;

endmodule : ex_branch_res

// File: logic/exe_stage.sv
`timescale 1ns/1ns

module exe_stage #(
	parameter int alg_steps = 16
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_types::lc3b_ipacket ipacket,
	input lc3b_types::lc3b_ipacket mem_ipacket,
	input lc3b_types::lc3b_word sext,
	input lc3b_types::lc3b_word sr1,
	input lc3b_types::lc3b_word sr2,
	input lc3b_types::lc3b_fwd_sel opa_sel,
	input lc3b_types::lc3b_fwd_sel opb_sel,
	input lc3b_types::lc3b_fwd_sel sr_sel,
	input lc3b_types::lc3b_word mem_data_forward,
	input lc3b_types::lc3b_word wb_data_forward,
	input lc3b_types::lc3b_word bubble_count,
	input lc3b_types::lc3b_word l1i_read_miss,
	input lc3b_types::lc3b_word l1i_write_miss,
	input lc3b_types::lc3b_word l1d_read_miss,
	input lc3b_types::lc3b_word l1d_write_miss,
	input lc3b_types::lc3b_word l2_read_miss,
	input lc3b_types::lc3b_word l2_write_miss,
	output lc3b_types::lc3b_word alu_out,
	output lc3b_types::lc3b_word bradd_out,
	output lc3b_types::lc3b_word sr_store,
	output lc3b_types::lc3b_word pc_addr_out,
	output lc3b_types::lc3b_pc_sel pcmux_sel,
	output logic br_taken,
	output logic pip_flush,
	output logic alg_done
);
	import lc3b_types::*;

	lc3b_word alumux_out;
	lc3b_word braddmux_out;
	lc3b_word opa;
	lc3b_word opb;
	lc3b_word alu_res;
	lc3b_word alg_hi;
	lc3b_word alg_lo;
	lc3b_word hi_reg;
	lc3b_word lo_reg;

	// select 3 gives zero
	function automatic lc3b_word fwd_mux(input lc3b_fwd_sel sel, input lc3b_word rf_val,
			input lc3b_word mem_val, input lc3b_word wb_val);
		case (sel)
			fwd_rf: return rf_val;
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return '0;
		endcase
	endfunction

	assign alumux_out = ipacket.alumux_sel ? sext : sr2;
	assign opa = fwd_mux(opa_sel, sr1, mem_data_forward, wb_data_forward);
	assign opb = fwd_mux(opb_sel, alumux_out, mem_data_forward, wb_data_forward);
	assign sr_store = fwd_mux(sr_sel, sr2, mem_data_forward, wb_data_forward);

	assign braddmux_out = ipacket.braddmux_sel ? sr2 : ipacket.pc;
	assign bradd_out = sext + braddmux_out;

	alu i_alu (
		.aluop(ipacket.aluop),
		.a(opa),
		.b(opb),
		.f(alu_res)
	);

	alg_unit #(
		.alg_steps(alg_steps)
	) i_alg_unit (
		.clk(clk),
		.reset(reset),
		.start(ipacket.alg_start),
		.op_x_bits(ipacket.op_x_bits),
		.opa(opa),
		.opb(opb),
		.done(alg_done),
		.hi_bits(alg_hi),
		.lo_bits(alg_lo)
	);

	// results become visible through selects 8 and 9 one cycle after done
	always_ff @(posedge clk) begin
		if (reset) begin
			hi_reg <= '0;
			lo_reg <= '0;
		end else if (alg_done && ipacket.load_alg_reg) begin
			hi_reg <= alg_hi;
			lo_reg <= alg_lo;
		end
	end

	always_comb begin
		case (ipacket.alu_res_sel)
			4'd0: alu_out = alu_res;
			4'd1: alu_out = bubble_count;
			4'd2: alu_out = l1i_read_miss;
			4'd3: alu_out = l1i_write_miss;
			4'd4: alu_out = l1d_read_miss;
			4'd5: alu_out = l1d_write_miss;
			4'd6: alu_out = l2_read_miss;
			4'd7: alu_out = l2_write_miss;
			4'd8: alu_out = lo_reg;
			4'd9: alu_out = hi_reg;
			default: alu_out = '0;
		endcase
	end

	ex_branch_res i_ex_branch_res (
		.ex_ipacket(ipacket),
		.mem_ipacket(mem_ipacket),
		.ex_alu_res(alu_out),
		.ex_addr_res(bradd_out),
		.mem_res(mem_data_forward),
		.stall(stall),
		.branch_enable(br_taken),
		.br_addr(pc_addr_out),
		.pcmux_sel(pcmux_sel),
		.flush(pip_flush)
	);

endmodule : exe_stage

// File: logic/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [3:0] lc3b_opcode;
	typedef logic [2:0] lc3b_aluop;
	// ordered n, z, p
	typedef logic [2:0] lc3b_nzp;
	typedef logic [1:0] lc3b_fwd_sel;
	typedef logic [3:0] lc3b_res_sel;
	typedef logic [1:0] lc3b_pc_sel;

	localparam lc3b_opcode op_br = 4'b0000;
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_jsr = 4'b0100;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;
	// multiply / divide extension, takes the unused rti slot
	localparam lc3b_opcode op_alg = 4'b1000;
	localparam lc3b_opcode op_not = 4'b1001;
	localparam lc3b_opcode op_jmp = 4'b1100;
	localparam lc3b_opcode op_shf = 4'b1101;

	localparam lc3b_aluop alu_add = 3'd0;
	localparam lc3b_aluop alu_and = 3'd1;
	localparam lc3b_aluop alu_not = 3'd2;
	localparam lc3b_aluop alu_pass_a = 3'd3;
	localparam lc3b_aluop alu_pass_b = 3'd4;
	localparam lc3b_aluop alu_sll = 3'd5;
	localparam lc3b_aluop alu_srl = 3'd6;
	localparam lc3b_aluop alu_sra = 3'd7;

	localparam lc3b_fwd_sel fwd_rf = 2'd0;
	localparam lc3b_fwd_sel fwd_mem = 2'd1;
	localparam lc3b_fwd_sel fwd_wb = 2'd2;

	localparam lc3b_pc_sel pc_seq = 2'd0;
	localparam lc3b_pc_sel pc_bradd = 2'd1;
	localparam lc3b_pc_sel pc_reg = 2'd2;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_word pc;
		lc3b_aluop aluop;
		// 0 takes sr2, 1 takes the sign-extended immediate
		logic alumux_sel;
		// 0 adds to pc, 1 adds to sr2
		logic braddmux_sel;
		lc3b_res_sel alu_res_sel;
		// 0 multiply, 1 divide
		logic op_x_bits;
		logic alg_start;
		logic load_alg_reg;
		lc3b_nzp nzp;
		lc3b_nzp cc;
		logic set_cc;
	} lc3b_ipacket;

endpackage : lc3b_types

// File: project.f
logic/lc3b_types.sv
logic/alu.sv
logic/alg_unit.sv
logic/ex_branch_res.sv
logic/exe_stage.sv
dv/exe_stage_chk.sv
dv/exe_stage_tb.sv
